// ==== filelist.f ====
+incdir+sim
rtl/fcs_pkg.sv
rtl/crc32.sv
rtl/crc_accum.sv
rtl/fcs_emitter.sv
rtl/fcs_check.sv
rtl/fcs_ctrl.sv
rtl/fcs_top.sv
sim/tb_fcs_top.sv

// ==== Bender.yml ====
package:
  name: fcs_unit

sources:
  # design sources in compile order
  - files:
      - rtl/fcs_pkg.sv
      - rtl/crc32.sv
      - rtl/crc_accum.sv
      - rtl/fcs_emitter.sv
      - rtl/fcs_check.sv
      - rtl/fcs_ctrl.sv
      - rtl/fcs_top.sv

  # testbench with its included CRC model
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_fcs_top.sv

// ==== sim/crc_model.svh ====
// crc_model
// bit-serial CRC-32 reference and frame builder of the testbench. The frame
// lives in the testbench queue frame_q, first byte first, and each byte
// enters the CRC from its top bit down
`ifndef CRC_MODEL_SVH
`define CRC_MODEL_SVH

// Ethernet generator polynomial with x^32 left implicit
localparam logic [31:0] MODEL_POLY = 32'h04C1_1DB7;

// one data bit into the LFSR
function automatic logic [31:0] serial_crc_step(input logic [31:0] crc, input logic din);
    logic [31:0] shifted;
    shifted = {crc[30:0], 1'b0};
    if (crc[31] ^ din)
    begin
        shifted = shifted ^ MODEL_POLY;
    end
    return shifted;
endfunction

// CRC of the whole queue, starting from all ones
function automatic logic [31:0] frame_crc();
    logic [31:0] crc;
    crc = 32'hFFFF_FFFF;
    foreach (frame_q[i])
    begin
        for (int b = 7; b >= 0; b--)
        begin
            crc = serial_crc_step(crc, frame_q[i][b]);
        end
    end
    return crc;
endfunction

// fresh random payload of len bytes
task automatic make_payload(input int len);
    frame_q.delete();
    for (int i = 0; i < len; i++)
    begin
        frame_q.push_back(8'($urandom));
    end
endtask

// the FCS is the complemented CRC, top byte first on the wire
task automatic append_fcs();
    logic [31:0] fcs;
    fcs = ~frame_crc();
    for (int s = 3; s >= 0; s--)
    begin
        frame_q.push_back(fcs[s*8 +: 8]);
    end
endtask

`endif

// ==== sim/tb_fcs_top.sv ====
// tb_fcs_top
// testbench of the FCS unit. Random frames go through all three lane
// widths, the generated FCS is compared chunk by chunk with a bit-serial
// model, and frames that carry their FCS are checked for good and bad

`timescale 1ns/1ps

module tb_fcs_top;

    import fcs_pkg::*;

    // about 21 frames of up to 96 beats with FCS and gaps fit well inside
    localparam int          MAX_CYCLES   = 3000;
    localparam logic [31:0] GOOD_RESIDUE = 32'hC704_DD7B;

    logic        clk = 1'b0;
    logic        reset;
    logic        in_valid;
    logic        in_sof;
    logic        in_eof;
    logic [7:0]  in_data;
    lane_mode_e  mode;
    logic        fcs_valid;
    logic [7:0]  fcs_data;
    logic        frame_done;
    logic        frame_ok;
    logic [15:0] bad_count;
    logic        busy;

    // frame under construction, read by the model in the header
    logic [7:0]  frame_q [$];

    // what the eof beat should produce, driven along with that beat
    logic        real_eof;
    logic [31:0] eof_fcs;
    int          eof_width;
    logic        eof_good;

    // expected outputs, stepped on every edge
    int          exp_left;
    int          exp_idx;
    int          exp_width;
    logic [31:0] exp_fcs;
    logic        exp_done;
    logic        exp_ok;
    logic [15:0] exp_bad;
    logic [7:0]  exp_chunk;

    int          cycle_count = 0;

`include "crc_model.svh"

    fcs_top #(
        .ERR_CNT_W (16)
    ) UUT (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_sof     (in_sof),
        .in_eof     (in_eof),
        .in_data    (in_data),
        .mode       (mode),
        .fcs_valid  (fcs_valid),
        .fcs_data   (fcs_data),
        .frame_done (frame_done),
        .frame_ok   (frame_ok),
        .bad_count  (bad_count),
        .busy       (busy)
    );

    always #5 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic int lane_bits(input lane_mode_e lane);
        return (lane == LANE_2) ? 2 : ((lane == LANE_4) ? 4 : 8);
    endfunction

    function automatic lane_mode_e random_lane();
        return lane_mode_e'($urandom_range(0, 2));
    endfunction

    // chunk idx of an FCS is the top lane bits of what is left, with the low bits zero
    function automatic logic [7:0] chunk_of(input logic [31:0] fcs, input int width,
                                            input int idx);
        logic [31:0] rest;
        logic [7:0]  mask;
        rest = fcs << (idx * width);
        mask = 8'hFF << (8 - width);
        return rest[31:24] & mask;
    endfunction

    assign exp_chunk = chunk_of(exp_fcs, exp_width, exp_idx);

    // --------------------------------------------------
    // expected outputs and timeout
    // --------------------------------------------------

    always @(posedge clk)
    begin
        if (reset)
        begin
            exp_left  <= 0;
            exp_idx   <= 0;
            exp_width <= 8;
            exp_fcs   <= 32'd0;
            exp_done  <= 1'b0;
            exp_ok    <= 1'b0;
            exp_bad   <= 16'd0;
        end
        else
        begin
            // strobes follow the eof beat by one cycle
            exp_done <= real_eof;
            exp_ok   <= real_eof && eof_good;
            if (real_eof && !eof_good)
            begin
                exp_bad <= exp_bad + 16'd1;
            end
            // 32 FCS bits in lane-width chunks right after the eof beat
            if (real_eof)
            begin
                exp_left  <= 32 / eof_width;
                exp_idx   <= 0;
                exp_width <= eof_width;
                exp_fcs   <= eof_fcs;
            end
            else if (exp_left != 0)
            begin
                exp_left <= exp_left - 1;
                exp_idx  <= exp_idx + 1;
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            fail_run($sformatf("timeout, the run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    // --------------------------------------------------
    // assertions
    // --------------------------------------------------

    a_fcs_valid: assert property (@(posedge clk) disable iff (reset)
        fcs_valid == (exp_left != 0))
        else fail_run($sformatf("ERR %0t ns: fcs_valid = %b, expected %b",
            $time, $sampled(fcs_valid), $sampled(exp_left) != 0));

    // data is only defined while a chunk is shown
    a_fcs_data: assert property (@(posedge clk) disable iff (reset)
        (exp_left == 0) || (fcs_data == exp_chunk))
        else fail_run($sformatf("ERR %0t ns: fcs_data = %h, expected %h",
            $time, $sampled(fcs_data), $sampled(exp_chunk)));

    a_frame_done: assert property (@(posedge clk) disable iff (reset)
        frame_done == exp_done)
        else fail_run($sformatf("ERR %0t ns: frame_done = %b, expected %b",
            $time, $sampled(frame_done), $sampled(exp_done)));

    a_frame_ok: assert property (@(posedge clk) disable iff (reset)
        frame_ok == exp_ok)
        else fail_run($sformatf("ERR %0t ns: frame_ok = %b, expected %b",
            $time, $sampled(frame_ok), $sampled(exp_ok)));

    a_bad_count: assert property (@(posedge clk) disable iff (reset)
        bad_count == exp_bad)
        else fail_run($sformatf("ERR %0t ns: bad_count = %0d, expected %0d",
            $time, $sampled(bad_count), $sampled(exp_bad)));

    // busy covers every cycle that shows an FCS chunk
    a_busy: assert property (@(posedge clk) disable iff (reset)
        busy == (exp_left != 0))
        else fail_run($sformatf("ERR %0t ns: busy = %b, expected %b",
            $time, $sampled(busy), $sampled(exp_left) != 0));

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------

    task automatic idle_inputs();
        in_valid <= 1'b0;
        in_sof   <= 1'b0;
        in_eof   <= 1'b0;
        in_data  <= 8'h00;
        real_eof <= 1'b0;
    endtask

    // sends frame_q at one lane width, optionally with junk beats while busy
    task automatic send_frame(input lane_mode_e lane, input bit junk_while_busy);
        int          width;
        int          per_byte;
        int          nbeats;
        int          n_junk;
        logic [31:0] full_crc;
        logic [7:0]  mask;
        logic [7:0]  lane_byte;
        width    = lane_bits(lane);
        per_byte = 8 / width;
        nbeats   = frame_q.size() * per_byte;
        n_junk   = junk_while_busy ? (32 / width) - 1 : 0;
        full_crc = frame_crc();
        mask     = 8'hFF << (8 - width);
        for (int k = 0; k < nbeats; k++)
        begin
            lane_byte = (frame_q[k / per_byte] << ((k % per_byte) * width)) & mask;
            @(posedge clk);
            in_valid  <= 1'b1;
            in_sof    <= (k == 0);
            in_eof    <= (k == nbeats - 1);
            // random low bits outside the lane must not reach the CRC
            in_data   <= lane_byte | (8'($urandom) & ~mask);
            // only the sof beat carries the real mode, the rest is noise
            mode      <= (k == 0) ? lane : random_lane();
            real_eof  <= (k == nbeats - 1);
            eof_fcs   <= ~full_crc;
            eof_width <= width;
            eof_good  <= (full_crc == GOOD_RESIDUE);
        end
        // these all land while the FCS is going out and must be dropped
        for (int j = 0; j < n_junk; j++)
        begin
            @(posedge clk);
            in_valid <= 1'b1;
            in_sof   <= 1'($urandom_range(0, 1));
            in_eof   <= 1'($urandom_range(0, 1));
            in_data  <= 8'($urandom);
            mode     <= random_lane();
            real_eof <= 1'b0;
        end
        @(posedge clk);
        idle_inputs();
        // busy rises on the edge after the eof beat, so look one edge later
        @(posedge clk);
        while (busy)
        begin
            @(posedge clk);
        end
    endtask

    initial
    begin
        int pos;
        // one fixed seed makes every run send the same frames
        void'($urandom(32'hf312_e5b0));
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_sof    = 1'b0;
        in_eof    = 1'b0;
        in_data   = 8'h00;
        mode      = LANE_8;
        real_eof  = 1'b0;
        eof_fcs   = 32'd0;
        eof_width = 8;
        eof_good  = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        // the assertions see the reset state on the next edges
        repeat (2) @(posedge clk);

        // one beat with both sof and eof
        make_payload(1);
        send_frame(LANE_8, 1'b0);

        for (int rep = 0; rep < 4; rep++)
        begin
            // same bits at all three widths give the same FCS
            make_payload($urandom_range(1, 16));
            send_frame(LANE_8, 1'b1);
            send_frame(LANE_4, 1'b0);
            send_frame(LANE_2, 1'b1);
            append_fcs();
            if (frame_crc() != GOOD_RESIDUE)
            begin
                fail_run("reference model does not leave the residue after a frame with its FCS");
            end
            send_frame(random_lane(), 1'b0);
            // a single flipped bit must turn the frame bad
            pos = $urandom_range(0, frame_q.size() * 8 - 1);
            frame_q[pos / 8] = frame_q[pos / 8] ^ (8'h01 << (pos % 8));
            send_frame(random_lane(), 1'b1);
        end

        repeat (2) @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== rtl/fcs_top.sv ====
// fcs_top
// frame check sequence unit for a 2, 4 or 8 bit MAC data stream. It
// generates the FCS that follows each frame and, for frames that
// already carry one, flags good frames and counts bad ones

`timescale 1ns/1ps

module fcs_top #(
    parameter int ERR_CNT_W = 16
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  logic                 in_sof,
    input  logic                 in_eof,
    input  logic [7:0]           in_data,
    input  fcs_pkg::lane_mode_e  mode,
    output logic                 fcs_valid,
    output logic [7:0]           fcs_data,
    output logic                 frame_done,
    output logic                 frame_ok,
    output logic [ERR_CNT_W-1:0] bad_count,
    output logic                 busy
);

    import fcs_pkg::*;

    logic        beat_take;
    logic        beat_first;
    logic        frame_end;
    logic        emit_active;
    lane_mode_e  lane_mode;
    // selected next CRC, on the eof beat this is the final CRC
    logic [31:0] crc_next;

    fcs_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_sof      (in_sof),
        .in_eof      (in_eof),
        .emit_active (emit_active),
        .mode        (mode),
        .beat_take   (beat_take),
        .beat_first  (beat_first),
        .frame_end   (frame_end),
        .busy        (busy),
        .lane_mode   (lane_mode)
    );

    crc_accum u_accum (
        .clk        (clk),
        .reset      (reset),
        .beat_take  (beat_take),
        .beat_first (beat_first),
        .lane_mode  (lane_mode),
        .data       (in_data),
        .crc_next   (crc_next)
    );

    // generator and checker both latch the same final CRC on frame_end
    fcs_emitter u_emitter (
        .clk         (clk),
        .reset       (reset),
        .frame_end   (frame_end),
        .lane_mode   (lane_mode),
        .crc_final   (crc_next),
        .emit_active (emit_active),
        .fcs_valid   (fcs_valid),
        .fcs_data    (fcs_data)
    );

    fcs_check #(
        .ERR_CNT_W (ERR_CNT_W)
    ) u_check (
        .clk        (clk),
        .reset      (reset),
        .frame_end  (frame_end),
        .crc_final  (crc_next),
        .frame_done (frame_done),
        .frame_ok   (frame_ok),
        .bad_count  (bad_count)
    );

endmodule

// ==== rtl/fcs_ctrl.sv ====
// fcs_ctrl
// frame state machine of the FCS unit. It decides which input beats are
// taken, holds the lane mode of the open frame, marks the end of a frame
// and keeps the unit busy while the FCS is being sent

`timescale 1ns/1ps

module fcs_ctrl (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  logic               in_sof,
    input  logic               in_eof,
    input  logic               emit_active,
    input  fcs_pkg::lane_mode_e mode,
    output logic               beat_take,
    output logic               beat_first,
    output logic               frame_end,
    output logic               busy,
    output fcs_pkg::lane_mode_e lane_mode
);

    import fcs_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_FRAME = 2'd1,
        ST_EMIT  = 2'd2
    } state_e;

    state_e     state_q;
    state_e     state_d;
    lane_mode_e mode_q;
    logic       frame_open;
    logic       can_start;

    // --------------------------------------------------
    // beat decisions
    // --------------------------------------------------

    assign frame_open = (state_q == ST_FRAME);
    // the last cycle in the emit state, once the emitter has finished,
    // already counts as idle so a new frame can start right away
    assign can_start  = (state_q == ST_IDLE) || ((state_q == ST_EMIT) && !emit_active);

    // a sof inside an open frame restarts it from scratch
    assign beat_first = in_valid && in_sof && (can_start || frame_open);
    // beats outside a frame and beats during emission fall through here
    assign beat_take  = in_valid && (beat_first || frame_open);
    assign frame_end  = beat_take && in_eof;

    assign busy = (state_q == ST_EMIT) && emit_active;

    // the sof beat itself already needs the new mode, later beats see the
    // latched copy so a mode change mid-frame does nothing
    assign lane_mode = beat_first ? mode : mode_q;

    // --------------------------------------------------
    // state
    // --------------------------------------------------

    always_comb
    begin
        state_d = state_q;
        if (frame_end)
        begin
            state_d = ST_EMIT;
        end
        else if (beat_first)
        begin
            state_d = ST_FRAME;
        end
        else if ((state_q == ST_EMIT) && !emit_active)
        begin
            state_d = ST_IDLE;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state_q <= ST_IDLE;
            mode_q  <= LANE_8;
        end
        else
        begin
            state_q <= state_d;
            if (beat_first)
            begin
                mode_q <= mode;
            end
        end
    end

endmodule

// ==== rtl/fcs_check.sv ====
// fcs_check
// compares the final CRC of a received frame against the fixed residue,
// gives a one-cycle done/good strobe pair and keeps a saturating count of
// frames that failed

`timescale 1ns/1ps

module fcs_check #(
    parameter int ERR_CNT_W = 16
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 frame_end,
    input  logic [31:0]          crc_final,
    output logic                 frame_done,
    output logic                 frame_ok,
    output logic [ERR_CNT_W-1:0] bad_count
);

    import fcs_pkg::*;

    logic crc_match;

    // a frame that carried a correct FCS always leaves the same residue
    assign crc_match = (crc_final == CRC_RESIDUE);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            frame_done <= 1'b0;
            frame_ok   <= 1'b0;
            bad_count  <= '0;
        end
        else
        begin
            // both strobes last one cycle and frame_ok is never high alone
            frame_done <= frame_end;
            frame_ok   <= frame_end && crc_match;
            // the counter stops at all ones instead of wrapping
            if (frame_end && !crc_match && !(&bad_count))
            begin
                bad_count <= bad_count + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/fcs_emitter.sv ====
// fcs_emitter
// sends the complemented final CRC of a frame as its FCS, top bits first,
// one lane-width chunk per cycle. The chunk sits left-aligned in the byte
// with the unused low bits at zero

`timescale 1ns/1ps

module fcs_emitter (
    input  logic               clk,
    input  logic               reset,
    input  logic               frame_end,
    input  fcs_pkg::lane_mode_e lane_mode,
    input  logic [31:0]        crc_final,
    output logic               emit_active,
    output logic               fcs_valid,
    output logic [7:0]         fcs_data
);

    import fcs_pkg::*;

    // remaining chunks, zero when nothing is being sent
    logic [4:0]  beat_cnt;
    lane_mode_e  emit_mode;
    // FCS bits not yet sent, always aligned to the top
    logic [31:0] fcs_shift;
    logic [7:0]  chunk;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            beat_cnt  <= 5'd0;
            emit_mode <= LANE_8;
        end
        else if (frame_end)
        begin
            // the lane width is captured here so the emission keeps it
            // even if control moves on
            beat_cnt  <= fcs_beats(lane_mode);
            emit_mode <= lane_mode;
        end
        else if (beat_cnt != 5'd0)
        begin
            beat_cnt <= beat_cnt - 5'd1;
        end
    end

    // the FCS is the one's complement of the final CRC
    always_ff @(posedge clk)
    begin
        if (frame_end)
        begin
            fcs_shift <= ~crc_final;
        end
        else if (beat_cnt != 5'd0)
        begin
            case (emit_mode)
                LANE_2:  fcs_shift <= {fcs_shift[29:0], 2'b00};
                LANE_4:  fcs_shift <= {fcs_shift[27:0], 4'b0000};
                default: fcs_shift <= {fcs_shift[23:0], 8'h00};
            endcase
        end
    end

    always_comb
    begin
        case (emit_mode)
            LANE_2:  chunk = {fcs_shift[31:30], 6'b000000};
            LANE_4:  chunk = {fcs_shift[31:28], 4'b0000};
            default: chunk = fcs_shift[31:24];
        endcase
    end

    assign fcs_valid   = (beat_cnt != 5'd0);
    assign emit_active = fcs_valid;
    // the output byte stays at zero between emissions
    assign fcs_data    = fcs_valid ? chunk : 8'h00;

endmodule

// ==== rtl/crc_accum.sv ====
// crc_accum
// running CRC-32 register of the current frame. A first beat is folded
// into the start value instead of the old register, and every taken beat
// loads the next value for the active lane width

`timescale 1ns/1ps

module crc_accum (
    input  logic               clk,
    input  logic               reset,
    input  logic               beat_take,
    input  logic               beat_first,
    input  fcs_pkg::lane_mode_e lane_mode,
    input  logic [7:0]         data,
    output logic [31:0]        crc_next
);

    import fcs_pkg::*;

    logic [31:0] crc_q;
    logic [31:0] crc_seed;
    logic [31:0] next_2b;
    logic [31:0] next_4b;
    logic [31:0] next_8b;

    // a new frame starts from all ones whatever the register still holds
    // from the previous frame
    assign crc_seed = beat_first ? CRC_INIT : crc_q;

    crc32 u_crc32 (
        .data       (data),
        .crc_in     (crc_seed),
        .crc_out_2b (next_2b),
        .crc_out_4b (next_4b),
        .crc_out_8b (next_8b)
    );

    // pick the step that matches the lane width of this frame
    always_comb
    begin
        case (lane_mode)
            LANE_2:  crc_next = next_2b;
            LANE_4:  crc_next = next_4b;
            default: crc_next = next_8b;
        endcase
    end

    // one register update per taken beat, idle cycles hold the value
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            crc_q <= CRC_INIT;
        end
        else if (beat_take)
        begin
            crc_q <= crc_next;
        end
    end

endmodule

// ==== rtl/crc32.sv ====
// crc32
// combinational next-state logic of the Ethernet CRC-32 (polynomial
// 04C11DB7) for 2, 4 and 8 data bits per step, most significant data bit
// first. Data is left-aligned: 2-bit steps use data[7:6], 4-bit steps use
// data[7:4]. All three results are produced at once and the caller picks
// the one that matches its lane width

`timescale 1ns/1ps

module crc32 (
    input  logic [7:0]  data,
    input  logic [31:0] crc_in,
    output logic [31:0] crc_out_2b,
    output logic [31:0] crc_out_4b,
    output logic [31:0] crc_out_8b
);

    // generator polynomial without the implicit x^32 term
    localparam logic [31:0] CRC_POLY = 32'h04C1_1DB7;

    // --------------------------------------------------
    // single bit step of the LFSR
    // --------------------------------------------------

    // the register shifts left and the polynomial is folded in whenever
    // the bit leaving the top differs from the incoming data bit
    function automatic logic [31:0] crc_bit_step(
        input logic [31:0] crc,
        input logic        din
    );
        logic feedback;
        feedback = crc[31] ^ din;
        return {crc[30:0], 1'b0} ^ (feedback ? CRC_POLY : 32'd0);
    endfunction

    // --------------------------------------------------
    // multi-bit steps
    // --------------------------------------------------

    // each loop unrolls at elaboration into a flat XOR tree, the order
    // of the loop is what makes the top data bit go in first

    // two bits per step, d[1] goes in before d[0]
    function automatic logic [31:0] next_crc_2b(
        input logic [1:0]  d,
        input logic [31:0] crc
    );
        logic [31:0] acc;
        acc = crc;
        for (int i = 1; i >= 0; i--)
        begin
            acc = crc_bit_step(acc, d[i]);
        end
        return acc;
    endfunction

    // four bits per step, d[3] goes in first
    function automatic logic [31:0] next_crc_4b(
        input logic [3:0]  d,
        input logic [31:0] crc
    );
        logic [31:0] acc;
        acc = crc;
        for (int i = 3; i >= 0; i--)
        begin
            acc = crc_bit_step(acc, d[i]);
        end
        return acc;
    endfunction

    // one full byte per step, d[7] goes in first
    function automatic logic [31:0] next_crc_8b(
        input logic [7:0]  d,
        input logic [31:0] crc
    );
        logic [31:0] acc;
        acc = crc;
        for (int i = 7; i >= 0; i--)
        begin
            acc = crc_bit_step(acc, d[i]);
        end
        return acc;
    endfunction

    // --------------------------------------------------
    // outputs
    // --------------------------------------------------

    // the narrow steps only look at the top of the byte, the low bits
    // are ignored in those modes
    assign crc_out_2b = next_crc_2b(data[7:6], crc_in);
    assign crc_out_4b = next_crc_4b(data[7:4], crc_in);
    assign crc_out_8b = next_crc_8b(data, crc_in);

endmodule

// ==== rtl/fcs_pkg.sv ====
// fcs_pkg
// shared definitions for the frame check sequence unit: the lane width
// selector, the CRC-32 start value, the good-frame residue and the number
// of beats an FCS takes at each lane width

package fcs_pkg;

    // lane width of one beat, data is always left-aligned in the byte
    typedef enum logic [1:0] {
        LANE_2 = 2'd0,
        LANE_4 = 2'd1,
        LANE_8 = 2'd2
    } lane_mode_e;

    // the running CRC starts from all ones on every frame
    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

    // value left in the register after a frame followed by its own
    // complemented FCS, sent most significant bit first
    localparam logic [31:0] CRC_RESIDUE = 32'hC704_DD7B;

    // beats needed to send 32 FCS bits at a given lane width
    function automatic logic [4:0] fcs_beats(input lane_mode_e lane);
        logic [4:0] beats;
        case (lane)
            LANE_2:
            begin
                beats = 5'd16;
            end
            LANE_4:
            begin
                beats = 5'd8;
            end
            default:
            begin
                beats = 5'd4;
            end
        endcase
        return beats;
    endfunction

endpackage
